// ==== Makefile ====
TOP := cache_tb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	@if grep -q "ERRORS FOUND" sim.log; then echo "simulation reported failures"; exit 1; fi
	@grep -q "NO ERRORS" sim.log || (echo "simulation ended without a result"; exit 1)

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// ==== bench/cache_assertions.sv ====
// pipeline timing assertions
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module cache_assertions (
  input logic                         clk,
  input logic                         rst,
  input logic                         req_valid,
  input logic [`CACHE_ADDR_WIDTH-1:0] req_addr,
  input logic                         rsp_valid,
  input logic                         fm_valid,
  input cache_pkg::fm_op_t            fm_op,
  input logic [`CACHE_ADDR_WIDTH-1:0] fm_addr
);
  import cache_pkg::*;

  int fail_count = 0;   // read by the testbench summary

  // fixed two cycle latency, both directions
  a_req_to_rsp: assert property (@(posedge clk) disable iff (rst) req_valid |-> ##2 rsp_valid)
    else begin $error("rsp_valid missing two cycles after req_valid"); fail_count++; end
  a_rsp_from_req: assert property (@(posedge clk) disable iff (rst)
                                   rsp_valid |-> $past(req_valid, 2))
    else begin $error("rsp_valid without a request two cycles earlier"); fail_count++; end

  // far memory only rides on a response, a fetch asks for the request address
  a_fm_with_rsp: assert property (@(posedge clk)
                                  fm_valid |-> rsp_valid &&
                                  (fm_op == DIRTY_EVICT_OP || fm_addr == $past(req_addr, 2)))
    else begin $error("fm_valid without rsp_valid or bad fm_addr"); fail_count++; end

  a_reset_quiet: assert property (@(posedge clk) rst |=> (!rsp_valid && !fm_valid))
    else begin $error("rsp_valid or fm_valid high after reset"); fail_count++; end

endmodule

bind cache_top cache_assertions u_assertions (
  .clk       (clk),
  .rst       (rst),
  .req_valid (req_valid),
  .req_addr  (req_addr),
  .rsp_valid (rsp_valid),
  .fm_valid  (fm_valid),
  .fm_op     (fm_op),
  .fm_addr   (fm_addr)
);

`default_nettype wire

// ==== bench/cache_tb.sv ====
// cache lookup testbench
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module cache_tb;
  import cache_pkg::*;

  localparam int RSP_TIMEOUT = 20;   // cycles per response wait

  logic                          clk;
  logic                          rst;
  logic                          req_valid;
  lookup_op_t                    req_op;
  logic [`CACHE_ADDR_WIDTH-1:0]  req_addr;
  word_t                         req_data;
  line_t                         req_line;
  logic [`CACHE_ID_WIDTH-1:0]    req_id;
  logic                          rsp_valid;
  lookup_result_t                rsp_result;
  logic [`CACHE_ID_WIDTH-1:0]    rsp_id;
  line_t                         rsp_line;
  logic                          fm_valid;
  fm_op_t                        fm_op;
  logic [`CACHE_ADDR_WIDTH-1:0]  fm_addr;
  line_t                         fm_line;

  integer                        seed;
  int                            err_count;
  int                            test_count;
  int                            err_total;
  logic [`CACHE_ID_WIDTH-1:0]    next_id;
  // response captured at the falling edge
  lookup_result_t                cap_result;
  logic [`CACHE_ID_WIDTH-1:0]    cap_id;
  line_t                         cap_line;
  logic                          cap_fm_valid;
  fm_op_t                        cap_fm_op;
  logic [`CACHE_ADDR_WIDTH-1:0]  cap_fm_addr;
  line_t                         cap_fm_line;
  line_t                         model_line [4];   // expected contents, random test set

  cache_top DUT (
    .clk (clk), .rst (rst),
    .req_valid (req_valid), .req_op (req_op), .req_addr (req_addr),
    .req_data (req_data), .req_line (req_line), .req_id (req_id),
    .rsp_valid (rsp_valid), .rsp_result (rsp_result), .rsp_id (rsp_id),
    .rsp_line (rsp_line), .fm_valid (fm_valid), .fm_op (fm_op),
    .fm_addr (fm_addr), .fm_line (fm_line)
  );

  always #50 clk = ~clk;   // 100 ns period

  //==========================================================
  // helpers
  //==========================================================
  function automatic logic [`CACHE_ADDR_WIDTH-1:0] make_addr(input tag_t tag,
                                                            input set_index_t set,
                                                            input word_offset_t word);
    return {tag, set, word};
  endfunction

  function automatic line_t rand_line();
    line_t l;
    for (int i = 0; i < `CACHE_WORDS_PER_LINE; i++) begin
      l[i] = $random(seed);
    end
    return l;
  endfunction

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      $display("Error: %s got %0h expected %0h", name, got, exp);
      err_count++;
    end
  endtask

  // entered at a falling edge, leaves at the next one
  task automatic drive_req(input lookup_op_t op, input logic [`CACHE_ADDR_WIDTH-1:0] addr,
                           input word_t data, input line_t line,
                           output logic [`CACHE_ID_WIDTH-1:0] id);
    id        = next_id;
    req_valid = 1'b1;
    req_op    = op;
    req_addr  = addr;
    req_data  = data;
    req_line  = line;
    req_id    = next_id;
    next_id++;
    @(negedge clk);
  endtask

  task automatic drive_idle();
    req_valid = 1'b0;
  endtask

  // looks at the current edge first so back to back responses are not skipped
  task automatic wait_rsp();
    int  cycles;
    bit  seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < RSP_TIMEOUT) begin
      if (rsp_valid) begin
        cap_result   = rsp_result;
        cap_id       = rsp_id;
        cap_line     = rsp_line;
        cap_fm_valid = fm_valid;
        cap_fm_op    = fm_op;
        cap_fm_addr  = fm_addr;
        cap_fm_line  = fm_line;
        seen         = 1'b1;
      end
      @(negedge clk);
      cycles++;
    end
    if (!seen) begin
      $display("timeout: no response within %0d cycles", RSP_TIMEOUT);
      $display("ERRORS FOUND");
      $finish;
    end
  endtask

  task automatic expect_rsp(input lookup_result_t result, input line_t line, input logic fm_v);
    check_value("rsp_result", cap_result, result);
    check_value("rsp_line", cap_line, line);
    check_value("fm_valid", cap_fm_valid, fm_v);
  endtask

  task automatic single_lookup(input lookup_op_t op, input logic [`CACHE_ADDR_WIDTH-1:0] addr,
                               input word_t data, input line_t line);
    logic [`CACHE_ID_WIDTH-1:0] id;
    drive_req(op, addr, data, line, id);
    drive_idle();
    wait_rsp();
    check_value("rsp_id", cap_id, id);
  endtask

  task automatic end_test(input string name, input int start_errs);
    test_count++;
    if (err_count == start_errs) $display("%s: pass", name);
    else $display("%s: fail, %0d errors", name, err_count - start_errs);
  endtask

  //==========================================================
  // directed tests
  //==========================================================
  task automatic test_read_miss();
    int                           start;
    logic [`CACHE_ADDR_WIDTH-1:0] addr;
    start = err_count;
    addr  = make_addr(10'h02a, 4'h3, 2'h1);
    single_lookup(RD_LU, addr, '0, '0);
    expect_rsp(MISS, '0, 1'b1);               // empty cache, fetch request
    check_value("fm_op", cap_fm_op, FILL_REQ_OP);
    check_value("fm_addr", cap_fm_addr, addr);
    end_test("read_miss", start);
  endtask

  task automatic test_fill_read();
    int    start;
    line_t line;
    start = err_count;
    line  = rand_line();
    single_lookup(FILL_LU, make_addr(10'h02a, 4'h3, 2'h0), '0, line);
    expect_rsp(FILL, line, 1'b0);             // free way, nothing to evict
    single_lookup(RD_LU, make_addr(10'h02a, 4'h3, 2'h2), '0, '0);
    expect_rsp(HIT, line, 1'b0);
    end_test("fill_read", start);
  endtask

  task automatic test_write_forward();
    int                         start;
    line_t                      line, merged;
    word_t                      data;
    logic [`CACHE_ID_WIDTH-1:0] id_wr, id_rd;
    start = err_count;
    line  = rand_line();
    data  = $random(seed);
    single_lookup(FILL_LU, make_addr(10'h155, 4'h7, 2'h0), '0, line);
    expect_rsp(FILL, line, 1'b0);
    merged    = line;
    merged[2] = data;
    // read right behind the write, needs both bypasses
    drive_req(WR_LU, make_addr(10'h155, 4'h7, 2'h2), data, '0, id_wr);
    drive_req(RD_LU, make_addr(10'h155, 4'h7, 2'h0), '0, '0, id_rd);
    drive_idle();
    wait_rsp();
    check_value("rsp_id", cap_id, id_wr);
    expect_rsp(HIT, '0, 1'b0);
    wait_rsp();
    check_value("rsp_id", cap_id, id_rd);
    expect_rsp(HIT, merged, 1'b0);
    end_test("write_forward", start);
  endtask

  task automatic test_mru_evict();
    int    start;
    line_t lines [4];
    line_t new_line, dirty;
    word_t data;
    start = err_count;
    for (int i = 0; i < 4; i++) begin
      lines[i] = rand_line();
      single_lookup(FILL_LU, make_addr(tag_t'(10'h100 + i), 4'h5, 2'h0), '0, lines[i]);
      expect_rsp(FILL, lines[i], 1'b0);        // ways 0..3 in order
    end
    // fourth fill makes all mru, flip leaves 1000
    data     = $random(seed);
    dirty    = lines[1];
    dirty[3] = data;
    single_lookup(WR_LU, make_addr(10'h101, 4'h5, 2'h3), data, '0);
    expect_rsp(HIT, '0, 1'b0);                 // mru 1010, way 1 modified
    single_lookup(RD_LU, make_addr(10'h102, 4'h5, 2'h0), '0, '0);
    expect_rsp(HIT, lines[2], 1'b0);           // mru 1110
    single_lookup(RD_LU, make_addr(10'h100, 4'h5, 2'h1), '0, '0);
    expect_rsp(HIT, lines[0], 1'b0);           // all mru again, flip to 0001
    // victim is way 1, first non mru, and it is dirty
    new_line = rand_line();
    single_lookup(FILL_LU, make_addr(10'h104, 4'h5, 2'h0), '0, new_line);
    expect_rsp(FILL, new_line, 1'b1);
    check_value("fm_op", cap_fm_op, DIRTY_EVICT_OP);
    check_value("fm_addr", cap_fm_addr, make_addr(10'h101, 4'h5, 2'h0));
    check_value("fm_line", cap_fm_line, dirty);
    single_lookup(RD_LU, make_addr(10'h101, 4'h5, 2'h0), '0, '0);
    expect_rsp(MISS, '0, 1'b1);
    check_value("fm_op", cap_fm_op, FILL_REQ_OP);
    single_lookup(RD_LU, make_addr(10'h104, 4'h5, 2'h2), '0, '0);
    expect_rsp(HIT, new_line, 1'b0);
    single_lookup(RD_LU, make_addr(10'h103, 4'h5, 2'h0), '0, '0);
    expect_rsp(HIT, lines[3], 1'b0);
    end_test("mru_evict", start);
  endtask

  task automatic test_random();
    int           start;
    int           idx;
    word_offset_t word;
    word_t        data;
    start = err_count;
    for (int i = 0; i < 4; i++) begin
      model_line[i] = rand_line();
      single_lookup(FILL_LU, make_addr(tag_t'(10'h300 + i), 4'h9, 2'h0), '0, model_line[i]);
      expect_rsp(FILL, model_line[i], 1'b0);
    end
    for (int n = 0; n < 24; n++) begin
      idx  = $random(seed) & 32'h3;
      word = word_offset_t'($random(seed));
      data = $random(seed);
      if ($random(seed) & 32'h1) begin
        single_lookup(WR_LU, make_addr(tag_t'(10'h300 + idx), 4'h9, word), data, '0);
        expect_rsp(HIT, '0, 1'b0);
        model_line[idx][word] = data;          // keep the model in step
      end else begin
        single_lookup(RD_LU, make_addr(tag_t'(10'h300 + idx), 4'h9, word), '0, '0);
        expect_rsp(HIT, model_line[idx], 1'b0);
      end
    end
    end_test("random_rw", start);
  endtask

  //==========================================================
  // main sequence
  //==========================================================
  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    req_valid  = 1'b0;
    req_op     = RD_LU;
    req_addr   = '0;
    req_data   = '0;
    req_line   = '0;
    req_id     = '0;
    seed       = 32'h4382;
    err_count  = 0;
    test_count = 0;
    next_id    = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_read_miss();
    test_fill_read();
    test_write_forward();
    test_mru_evict();
    test_random();

    err_total = err_count + DUT.u_assertions.fail_count;
    $display("tests %0d, check errors %0d, assertion failures %0d",
             test_count, err_count, DUT.u_assertions.fail_count);
    if (err_total == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+source
source/cache_pkg.sv
source/way_bus_if.sv
source/way_ram.sv
source/cache_way.sv
source/lookup_decode.sv
source/way_select.sv
source/lookup_respond.sv
source/cache_top.sv
bench/cache_assertions.sv
bench/cache_tb.sv

// ==== source/cache_defs.svh ====
// cache geometry macros
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// set organization
`define CACHE_NUM_WAYS        4   // ways per set
`define CACHE_NUM_SETS        16  // sets in the cache

// line layout
`define CACHE_WORD_WIDTH      32  // bits per word
`define CACHE_WORDS_PER_LINE  4   // words per line

// word address = {tag, set, word offset}
`define CACHE_TAG_WIDTH       10
`define CACHE_ADDR_WIDTH      16

// requester tag carried through the pipe
`define CACHE_ID_WIDTH        8

`endif

// ==== source/cache_pkg.sv ====
// cache type package
`default_nettype none
`include "cache_defs.svh"

package cache_pkg;

  typedef logic [$clog2(`CACHE_NUM_WAYS)-1:0]       way_index_t;
  typedef logic [$clog2(`CACHE_NUM_SETS)-1:0]       set_index_t;
  typedef logic [$clog2(`CACHE_WORDS_PER_LINE)-1:0] word_offset_t; // word inside a line
  typedef logic [`CACHE_TAG_WIDTH-1:0]              tag_t;
  typedef logic [`CACHE_WORD_WIDTH-1:0]             word_t;
  typedef word_t [`CACHE_WORDS_PER_LINE-1:0]        line_t;
  typedef logic [`CACHE_NUM_WAYS-1:0]               way_vec_t;  // one bit per way

  typedef enum logic [1:0] {RD_LU, WR_LU, FILL_LU} lookup_op_t;
  typedef enum logic [1:0] {HIT, MISS, FILL} lookup_result_t;
  typedef enum logic {FILL_REQ_OP, DIRTY_EVICT_OP} fm_op_t;

  // per way, per set state
  typedef struct packed {
    logic valid;
    logic modified;
    logic mru;
    tag_t tag;
  } way_meta_t;

  // pipe bus, one lookup
  typedef struct packed {
    logic                                  valid;
    lookup_op_t                            op;
    tag_t                                  tag;
    set_index_t                            set;
    word_offset_t                          word;
    word_t                                 wr_word;    // write data
    line_t                                 fill_line;  // fill data
    logic [`CACHE_ID_WIDTH-1:0]            id;
    way_vec_t                              hit;        // filled in q2
    way_vec_t                              victim;     // filled in q2
    way_meta_t [`CACHE_NUM_WAYS-1:0]       meta;       // set state before the update
  } lookup_t;

endpackage

`default_nettype wire

// ==== source/cache_top.sv ====
// data cache lookup pipe
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module cache_top (
  input  logic                           clk,
  input  logic                           rst,
  // lookup request
  input  logic                           req_valid,
  input  cache_pkg::lookup_op_t          req_op,
  input  logic [`CACHE_ADDR_WIDTH-1:0]   req_addr,
  input  cache_pkg::word_t               req_data,
  input  cache_pkg::line_t               req_line,
  input  logic [`CACHE_ID_WIDTH-1:0]     req_id,
  // lookup response
  output logic                           rsp_valid,
  output cache_pkg::lookup_result_t      rsp_result,
  output logic [`CACHE_ID_WIDTH-1:0]     rsp_id,
  output cache_pkg::line_t               rsp_line,
  // far memory
  output logic                           fm_valid,
  output cache_pkg::fm_op_t              fm_op,
  output logic [`CACHE_ADDR_WIDTH-1:0]   fm_addr,
  output cache_pkg::line_t               fm_line
);
  import cache_pkg::*;

  lookup_t  lookup_q2, lookup_q3;
  way_vec_t hit;

  way_bus_if ways ();

  lookup_decode u_decode (
    .clk (clk), .rst (rst),
    .req_valid (req_valid), .req_op (req_op), .req_addr (req_addr),
    .req_data (req_data), .req_line (req_line), .req_id (req_id),
    .ways (ways), .lookup_q2 (lookup_q2)
  );

  for (genvar i = 0; i < `CACHE_NUM_WAYS; i++) begin : g_way
    cache_way #(.WAY_INDEX(i)) u_way (
      .clk (clk), .rst (rst), .ways (ways), .lookup_q2 (lookup_q2), .hit (hit[i])
    );
  end

  way_select u_select (
    .clk (clk), .rst (rst), .lookup_q2 (lookup_q2), .hit (hit),
    .ways (ways), .lookup_q3 (lookup_q3)
  );

  lookup_respond u_respond (
    .lookup_q3 (lookup_q3), .ways (ways),
    .rsp_valid (rsp_valid), .rsp_result (rsp_result), .rsp_id (rsp_id),
    .rsp_line (rsp_line), .fm_valid (fm_valid), .fm_op (fm_op),
    .fm_addr (fm_addr), .fm_line (fm_line)
  );

endmodule

`default_nettype wire

// ==== source/cache_way.sv ====
// one cache way
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module cache_way #(
  parameter int WAY_INDEX = 0
) (
  input  logic               clk,
  input  logic               rst,
  way_bus_if.way             ways,
  input  cache_pkg::lookup_t lookup_q2,
  output logic               hit
);
  import cache_pkg::*;

  way_meta_t meta_q2;   // this way's entry of the q2 set
  line_t     line_q3;   // this way's line for q3

  way_ram #(.T(way_meta_t), .DEPTH(`CACHE_NUM_SETS)) u_meta_ram (
    .clk     (clk),
    .rst     (rst),
    .rd_en   (ways.meta_rd_en),
    .rd_idx  (ways.meta_rd_set),
    .rd_data (meta_q2),
    .wr_en   (ways.meta_wr_en),
    .wr_idx  (lookup_q2.set),        // write back the set read in q1
    .wr_data (ways.meta_wr[WAY_INDEX])
  );

  way_ram #(.T(line_t), .DEPTH(`CACHE_NUM_SETS)) u_line_ram (
    .clk     (clk),
    .rst     (rst),
    .rd_en   (ways.line_rd_en[WAY_INDEX]),
    .rd_idx  (ways.line_rd_idx),
    .rd_data (line_q3),
    .wr_en   (ways.line_wr_en[WAY_INDEX]),
    .wr_idx  (ways.line_wr_idx),
    .wr_data (ways.line_wr)
  );

  assign ways.meta_rd[WAY_INDEX] = meta_q2;
  assign ways.line_rd[WAY_INDEX] = line_q3;

  // tag compare
  assign hit = lookup_q2.valid && meta_q2.valid && (meta_q2.tag == lookup_q2.tag);

endmodule

`default_nettype wire

// ==== source/lookup_decode.sv ====
// q1 lookup decode
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module lookup_decode (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            req_valid,
  input  cache_pkg::lookup_op_t           req_op,
  input  logic [`CACHE_ADDR_WIDTH-1:0]    req_addr,
  input  cache_pkg::word_t                req_data,
  input  cache_pkg::line_t                req_line,
  input  logic [`CACHE_ID_WIDTH-1:0]      req_id,
  way_bus_if.decode                       ways,
  output cache_pkg::lookup_t              lookup_q2
);
  import cache_pkg::*;

  lookup_t lookup_q1;

  always_comb begin
    lookup_q1           = '0;   // vectors and meta are filled in q2
    lookup_q1.valid     = req_valid;
    lookup_q1.op        = req_op;
    {lookup_q1.tag, lookup_q1.set, lookup_q1.word} = req_addr;
    lookup_q1.wr_word   = req_data;
    lookup_q1.fill_line = req_line;
    lookup_q1.id        = req_id;
  end

  // set read, data returns with the q2 lookup
  assign ways.meta_rd_en  = req_valid;
  assign ways.meta_rd_set = lookup_q1.set;

  always_ff @(posedge clk) begin
    lookup_q2 <= lookup_q1;
    if (rst) lookup_q2.valid <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== source/lookup_respond.sv ====
// q3 response and data write
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module lookup_respond (
  input  cache_pkg::lookup_t             lookup_q3,
  way_bus_if.respond                     ways,
  output logic                           rsp_valid,
  output cache_pkg::lookup_result_t      rsp_result,
  output logic [`CACHE_ID_WIDTH-1:0]     rsp_id,
  output cache_pkg::line_t               rsp_line,
  output logic                           fm_valid,
  output cache_pkg::fm_op_t              fm_op,
  output logic [`CACHE_ADDR_WIDTH-1:0]   fm_addr,
  output cache_pkg::line_t               fm_line
);
  import cache_pkg::*;

  way_vec_t   access;
  way_index_t sel_idx;       // encoded hit or victim way
  line_t      sel_line;      // line read in q2
  line_t      merged;
  logic       is_fill, is_hit, is_miss, dirty_evict;

  assign is_fill = (lookup_q3.op == FILL_LU);
  assign is_hit  = (lookup_q3.hit != '0);
  assign is_miss = !is_hit && !is_fill;
  assign access  = is_fill ? lookup_q3.victim : lookup_q3.hit;

  always_comb begin
    sel_idx = '0;
    for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
      if (access[w]) sel_idx = way_index_t'(w);
    end
  end

  assign sel_line = ways.line_rd[sel_idx];

  // write hit word merge
  always_comb begin
    merged                 = sel_line;
    merged[lookup_q3.word] = lookup_q3.wr_word;
  end

  //==========================================================
  // data write
  //==========================================================
  always_comb begin
    ways.line_wr_en = '0;
    if (lookup_q3.valid && is_fill) ways.line_wr_en = lookup_q3.victim;
    if (lookup_q3.valid && (lookup_q3.op == WR_LU)) ways.line_wr_en = lookup_q3.hit;
  end
  assign ways.line_wr_idx = lookup_q3.set;
  assign ways.line_wr     = is_fill ? lookup_q3.fill_line : merged;

  //==========================================================
  // response
  //==========================================================
  assign rsp_valid  = lookup_q3.valid;
  assign rsp_result = is_fill ? FILL : (is_hit ? HIT : MISS);
  assign rsp_id     = lookup_q3.id;
  assign rsp_line   = is_fill                                 ? lookup_q3.fill_line :
                      ((lookup_q3.op == RD_LU) && is_hit)     ? sel_line            :
                                                                '0;

  // far memory, miss fetch or dirty victim writeback
  assign dirty_evict = is_fill && lookup_q3.meta[sel_idx].valid
                               && lookup_q3.meta[sel_idx].modified;

  assign fm_valid = lookup_q3.valid && (is_miss || dirty_evict);
  assign fm_op    = dirty_evict ? DIRTY_EVICT_OP : FILL_REQ_OP;
  assign fm_addr  = dirty_evict ?
                    {lookup_q3.meta[sel_idx].tag, lookup_q3.set, word_offset_t'(0)} :
                    {lookup_q3.tag, lookup_q3.set, lookup_q3.word};
  assign fm_line  = dirty_evict ? sel_line : '0;   // old line out

endmodule

`default_nettype wire

// ==== source/way_bus_if.sv ====
// per way array bus
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

interface way_bus_if;
  import cache_pkg::*;

  // q1 metadata read, same set on every way
  logic                             meta_rd_en;
  set_index_t                       meta_rd_set;
  way_meta_t [`CACHE_NUM_WAYS-1:0]  meta_rd;     // one slice per way
  // q2 metadata write, set comes from the q2 lookup
  logic                             meta_wr_en;
  way_meta_t [`CACHE_NUM_WAYS-1:0]  meta_wr;
  // q2 line read, only the selected way
  way_vec_t                         line_rd_en;
  set_index_t                       line_rd_idx;
  line_t [`CACHE_NUM_WAYS-1:0]      line_rd;
  // q3 line write
  way_vec_t                         line_wr_en;
  set_index_t                       line_wr_idx;
  line_t                            line_wr;

  modport decode  (output meta_rd_en, meta_rd_set);
  modport way     (input  meta_rd_en, meta_rd_set, meta_wr_en, meta_wr,
                          line_rd_en, line_rd_idx, line_wr_en, line_wr_idx, line_wr,
                   output meta_rd, line_rd);
  modport select  (input  meta_rd,
                   output meta_wr_en, meta_wr, line_rd_en, line_rd_idx);
  modport respond (input  line_rd,
                   output line_wr_en, line_wr_idx, line_wr);

endinterface

`default_nettype wire

// ==== source/way_ram.sv ====
// synchronous read array
`timescale 1ns/1ps
`default_nettype none

module way_ram #(
  parameter type T     = logic [31:0],
  parameter int  DEPTH = 16
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     rd_en,
  input  logic [$clog2(DEPTH)-1:0] rd_idx,
  output T                         rd_data,
  input  logic                     wr_en,
  input  logic [$clog2(DEPTH)-1:0] wr_idx,
  input  T                         wr_data
);

  T mem [DEPTH];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;   // all entries start invalid
      end
      rd_data <= '0;
    end else begin
      if (wr_en) mem[wr_idx] <= wr_data;
      // same cycle write at the read index wins
      if (rd_en) rd_data <= (wr_en && (wr_idx == rd_idx)) ? wr_data : mem[rd_idx];
    end
  end

endmodule

`default_nettype wire

// ==== source/way_select.sv ====
// q2 tag select and set update
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module way_select (
  input  logic                clk,
  input  logic                rst,
  input  cache_pkg::lookup_t  lookup_q2,
  input  cache_pkg::way_vec_t hit,
  way_bus_if.select           ways,
  output cache_pkg::lookup_t  lookup_q3
);
  import cache_pkg::*;

  way_meta_t [`CACHE_NUM_WAYS-1:0] old_meta;
  way_vec_t old_valid, old_mru, old_mod;
  way_vec_t victim;      // one hot, fills only
  way_vec_t access;      // way touched by this lookup
  way_vec_t new_valid, new_mru, new_mod;
  logic     is_fill;
  lookup_t  lookup_d;

  // lowest set bit
  function automatic way_vec_t first_one(input way_vec_t v);
    return v & (~v + 1'b1);
  endfunction

  assign old_meta = ways.meta_rd;
  assign is_fill  = lookup_q2.valid && (lookup_q2.op == FILL_LU);

  always_comb begin
    for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
      old_valid[w] = old_meta[w].valid;
      old_mru[w]   = old_meta[w].mru;
      old_mod[w]   = old_meta[w].modified;
    end
  end

  //==========================================================
  // victim allocation
  //==========================================================
  always_comb begin
    victim = '0;
    if (is_fill) begin
      // free way first, else first non mru way (flip keeps one)
      victim = (~old_valid != '0) ? first_one(~old_valid) : first_one(~old_mru);
    end
  end

  assign access = is_fill ? victim : hit;

  //==========================================================
  // set state update
  //==========================================================
  always_comb begin
    new_valid = old_valid;
    new_mru   = old_mru;
    new_mod   = old_mod;
    if (lookup_q2.valid && (lookup_q2.op == RD_LU)) begin
      new_mru = old_mru | hit;              // read hit, no change on miss
    end
    if (lookup_q2.valid && (lookup_q2.op == WR_LU)) begin
      new_mru = old_mru | hit;
      new_mod = old_mod | hit;              // line now dirty
    end
    if (is_fill) begin
      new_mru   = old_mru | victim;
      new_valid = old_valid | victim;
      new_mod   = old_mod & ~victim;        // fill data is clean
    end
    // all mru, keep only the accessed way
    if ((&new_mru) && (access != '0)) new_mru = access;
  end

  always_comb begin
    for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
      ways.meta_wr[w].valid    = new_valid[w];
      ways.meta_wr[w].modified = new_mod[w];
      ways.meta_wr[w].mru      = new_mru[w];
      ways.meta_wr[w].tag      = victim[w] ? lookup_q2.tag : old_meta[w].tag;
    end
  end

  assign ways.meta_wr_en  = lookup_q2.valid && (access != '0); // misses leave the set alone

  // line read of the hit or victim way, old line for a dirty evict
  assign ways.line_rd_en  = lookup_q2.valid ? access : '0;
  assign ways.line_rd_idx = lookup_q2.set;

  //==========================================================
  // q3 register
  //==========================================================
  always_comb begin
    lookup_d        = lookup_q2;
    lookup_d.hit    = hit;
    lookup_d.victim = victim;
    lookup_d.meta   = old_meta;   // evict needs the old tag
  end

  always_ff @(posedge clk) begin
    lookup_q3 <= lookup_d;
    if (rst) lookup_q3.valid <= 1'b0;
  end

endmodule

`default_nettype wire
